// ==== Bender.yml ====
package:
  name: exec_cluster

export_include_dirs:
  - .

sources:
  - files:
      - rv32i_isa_pkg.sv
      - ooo_types_pkg.sv
      - issue_decoder.sv
      - reservation_station.sv
      - alu_unit.sv
      - cmp_unit.sv
      - cdb_arbiter.sv
      - exec_cluster.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_exec_cluster.sv

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`include "ooo_consts.svh"

module alu_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  ooo_types_pkg::dispatch_t disp,
	input  logic                     grant,
	input  ooo_types_pkg::flush_t    flush,
	output logic                     unit_ready,
	output ooo_types_pkg::result_t   result
);
	import rv32i_isa_pkg::*;
	import ooo_types_pkg::*;

	logic [`XLEN_W-1:0] y;
	logic               disp_young;
	logic               held_young;

	always_comb begin
		case (alu_op_t'(disp.op))
			alu_add: y = disp.a + disp.b;
			alu_sub: y = disp.a - disp.b;
			alu_sll: y = disp.a << disp.b[4:0];
			alu_xor: y = disp.a ^ disp.b;
			alu_srl: y = disp.a >> disp.b[4:0];
			alu_sra: y = $signed(disp.a) >>> disp.b[4:0];
			alu_or:  y = disp.a | disp.b;
			alu_and: y = disp.a & disp.b;
			default: y = disp.a + disp.b;
		endcase
	end

	// free when empty or when the held word leaves this cycle
	assign unit_ready = !result.valid || grant;
	assign disp_young = flush.valid && !tag_is_older(disp.tag, flush);
	assign held_young = flush.valid && !tag_is_older(result.tag, flush);

	always_ff @(posedge clk) begin
		if (rst) begin
			result.valid <= 1'b0;
		end else if (disp.valid && unit_ready && !disp_young) begin
			result.valid <= 1'b1;
			result.tag   <= disp.tag;
			result.value <= y;
		end else if (grant || held_young) begin
			result.valid <= 1'b0;
		end
	end

endmodule

// ==== cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	input  ooo_types_pkg::result_t alu_result,
	input  ooo_types_pkg::result_t cmp_result,
	output logic                   alu_grant,
	output logic                   cmp_grant,
	output ooo_types_pkg::result_t cdb
);

	// consecutive cycles the alu held a result without a grant
	logic [1:0] starve_cnt;
	logic       alu_first;

	assign alu_first = starve_cnt == 2'd2;

	always_comb begin
		cmp_grant = cmp_result.valid && !(alu_first && alu_result.valid);
		alu_grant = alu_result.valid && !cmp_grant;
		// an idle alu word carries valid low onto the bus
		cdb = cmp_grant ? cmp_result : alu_result;
	end

	// the count never passes 2, the alu wins on that cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			starve_cnt <= 2'd0;
		end else if (alu_result.valid && !alu_grant) begin
			starve_cnt <= starve_cnt + 2'd1;
		end else begin
			starve_cnt <= 2'd0;
		end
	end

endmodule

// ==== cmp_unit.sv ====
`timescale 1ns/1ps
`include "ooo_consts.svh"

module cmp_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  ooo_types_pkg::dispatch_t disp,
	input  logic                     grant,
	input  ooo_types_pkg::flush_t    flush,
	output logic                     unit_ready,
	output ooo_types_pkg::result_t   result
);
	import rv32i_isa_pkg::*;
	import ooo_types_pkg::*;

	logic taken;
	logic disp_young;
	logic held_young;

	// slt and sltu arrive here as blt and bltu
	always_comb begin
		case (cmp_op_t'(disp.op))
			cmp_beq:  taken = disp.a == disp.b;
			cmp_bne:  taken = disp.a != disp.b;
			cmp_blt:  taken = $signed(disp.a) < $signed(disp.b);
			cmp_bge:  taken = $signed(disp.a) >= $signed(disp.b);
			cmp_bltu: taken = disp.a < disp.b;
			cmp_bgeu: taken = disp.a >= disp.b;
			default:  taken = 1'b0;
		endcase
	end

	assign unit_ready = !result.valid || grant;
	assign disp_young = flush.valid && !tag_is_older(disp.tag, flush);
	assign held_young = flush.valid && !tag_is_older(result.tag, flush);

	always_ff @(posedge clk) begin
		if (rst) begin
			result.valid <= 1'b0;
		end else if (disp.valid && unit_ready && !disp_young) begin
			result.valid <= 1'b1;
			result.tag   <= disp.tag;
			result.value <= {{(`XLEN_W-1){1'b0}}, taken};
		end else if (grant || held_young) begin
			result.valid <= 1'b0;
		end
	end

endmodule

// ==== exec_cluster.f ====
+incdir+.
rv32i_isa_pkg.sv
ooo_types_pkg.sv
issue_decoder.sv
reservation_station.sv
alu_unit.sv
cmp_unit.sv
cdb_arbiter.sv
exec_cluster.sv
tb_clock_gen.sv
tb_exec_cluster.sv

// ==== exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue_valid [2],
	input  rv32i_isa_pkg::pci_t    issue_pci [2],
	input  ooo_types_pkg::src_t    issue_r1 [2],
	input  ooo_types_pkg::src_t    issue_r2 [2],
	input  ooo_types_pkg::tag_t    issue_tag [2],
	input  ooo_types_pkg::result_t rob_wakeup,
	input  ooo_types_pkg::flush_t  flush,
	output logic                   issue_ready,
	output ooo_types_pkg::result_t cdb
);
	import ooo_types_pkg::*;

	rs_entry_t dec_entry [2];
	dispatch_t alu_disp;
	dispatch_t cmp_disp;
	result_t   alu_result;
	result_t   cmp_result;
	logic      alu_ready;
	logic      cmp_ready;
	logic      alu_grant;
	logic      cmp_grant;

	for (genvar s = 0; s < 2; s++) begin : g_dec
		issue_decoder i_dec (
			.pci        (issue_pci[s]),
			.r1         (issue_r1[s]),
			.r2         (issue_r2[s]),
			.tag        (issue_tag[s]),
			.cdb        (cdb),
			.rob_wakeup (rob_wakeup),
			.entry      (dec_entry[s])
		);
	end

	reservation_station i_rs (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.new_entry   (dec_entry),
		.cdb         (cdb),
		.rob_wakeup  (rob_wakeup),
		.flush       (flush),
		.alu_ready   (alu_ready),
		.cmp_ready   (cmp_ready),
		.issue_ready (issue_ready),
		.alu_disp    (alu_disp),
		.cmp_disp    (cmp_disp)
	);

	alu_unit i_alu (
		.clk        (clk),
		.rst        (rst),
		.disp       (alu_disp),
		.grant      (alu_grant),
		.flush      (flush),
		.unit_ready (alu_ready),
		.result     (alu_result)
	);

	cmp_unit i_cmp (
		.clk        (clk),
		.rst        (rst),
		.disp       (cmp_disp),
		.grant      (cmp_grant),
		.flush      (flush),
		.unit_ready (cmp_ready),
		.result     (cmp_result)
	);

	cdb_arbiter i_arb (
		.clk        (clk),
		.rst        (rst),
		.alu_result (alu_result),
		.cmp_result (cmp_result),
		.alu_grant  (alu_grant),
		.cmp_grant  (cmp_grant),
		.cdb        (cdb)
	);

endmodule

// ==== issue_decoder.sv ====
`timescale 1ns/1ps
`include "ooo_consts.svh"

module issue_decoder (
	input  rv32i_isa_pkg::pci_t      pci,
	input  ooo_types_pkg::src_t      r1,
	input  ooo_types_pkg::src_t      r2,
	input  ooo_types_pkg::tag_t      tag,
	input  ooo_types_pkg::result_t   cdb,
	input  ooo_types_pkg::result_t   rob_wakeup,
	output ooo_types_pkg::rs_entry_t entry
);
	import rv32i_isa_pkg::*;
	import ooo_types_pkg::*;

	src_t               s1;
	src_t               s2;
	arith_funct3_t      f3;
	logic [`XLEN_W-1:0] shamt;

	function automatic src_t imm_src(logic [`XLEN_W-1:0] v);
		src_t s;
		s.busy     = 1'b0;
		s.op.value = v;
		return s;
	endfunction

	assign f3    = arith_funct3_t'(pci.funct3);
	assign shamt = {{(`XLEN_W-5){1'b0}}, pci.i_imm[4:0]};

	always_comb begin
		entry          = '0;
		entry.valid    = 1'b1;
		entry.tag      = tag;
		entry.unit_cmp = 1'b0;
		entry.alu_op   = alu_op_t'(pci.funct3);
		entry.cmp_op   = cmp_op_t'(pci.funct3);
		s1 = r1;
		s2 = r2;
		case (pci.opcode)
			op_lui: begin
				entry.alu_op = alu_add;
				s1 = imm_src(pci.u_imm);
				s2 = imm_src('0);
			end
			op_auipc: begin
				entry.alu_op = alu_add;
				s1 = imm_src(pci.pc);
				s2 = imm_src(pci.u_imm);
			end
			// jump target only, the link value is not produced here
			op_jal: begin
				entry.alu_op = alu_add;
				s1 = imm_src(pci.pc);
				s2 = imm_src(pci.j_imm);
			end
			op_jalr: begin
				entry.alu_op = alu_add;
				s2 = imm_src(pci.i_imm);
			end
			op_br: begin
				entry.unit_cmp = 1'b1;
			end
			op_imm: begin
				s2 = imm_src(pci.i_imm);
				case (f3)
					f3_slt: begin
						entry.unit_cmp = 1'b1;
						entry.cmp_op   = cmp_blt;
					end
					f3_sltu: begin
						entry.unit_cmp = 1'b1;
						entry.cmp_op   = cmp_bltu;
					end
					f3_sll: s2 = imm_src(shamt);
					f3_sr: begin
						s2 = imm_src(shamt);
						if (pci.funct7[5]) begin
							entry.alu_op = alu_sra;
						end
					end
					default: ;
				endcase
			end
			op_reg: begin
				case (f3)
					f3_slt: begin
						entry.unit_cmp = 1'b1;
						entry.cmp_op   = cmp_blt;
					end
					f3_sltu: begin
						entry.unit_cmp = 1'b1;
						entry.cmp_op   = cmp_bltu;
					end
					f3_add: if (pci.funct7[5]) entry.alu_op = alu_sub;
					f3_sr:  if (pci.funct7[5]) entry.alu_op = alu_sra;
					default: ;
				endcase
			end
			default: ;
		endcase
		// bypass anything broadcast in the issue cycle itself
		entry.src1 = wake_src(s1, cdb, rob_wakeup);
		entry.src2 = wake_src(s2, cdb, rob_wakeup);
	end

endmodule

// ==== ooo_consts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// datapath width
`define XLEN_W 32

// rob tag width, 16 tags in flight
`define TAG_W 4

// default number of station entries
`define RS_DEPTH 8

`endif

// ==== ooo_types_pkg.sv ====
`include "ooo_consts.svh"

package ooo_types_pkg;

	typedef logic [`TAG_W-1:0] tag_t;

	// one register word, holding either a value or the rob tag of its producer
	typedef union packed {
		logic [`XLEN_W-1:0] value;
		struct packed {
			logic [`XLEN_W-`TAG_W-1:0] pad;
			tag_t                      tag;
		} rob;
	} operand_u;

	// busy says which view of op is live
	typedef struct packed {
		logic     busy;
		operand_u op;
	} src_t;

	typedef struct packed {
		logic                   valid;
		tag_t                   tag;
		// 0 goes to the alu, 1 to the compare unit
		logic                   unit_cmp;
		rv32i_isa_pkg::alu_op_t alu_op;
		rv32i_isa_pkg::cmp_op_t cmp_op;
		src_t                   src1;
		src_t                   src2;
	} rs_entry_t;

	typedef struct packed {
		logic               valid;
		tag_t               tag;
		logic [2:0]         op;
		logic [`XLEN_W-1:0] a;
		logic [`XLEN_W-1:0] b;
	} dispatch_t;

	typedef struct packed {
		logic               valid;
		tag_t               tag;
		logic [`XLEN_W-1:0] value;
	} result_t;

	typedef struct packed {
		logic valid;
		tag_t front_tag;
		tag_t flush_tag;
	} flush_t;

	// true for tags in [front_tag, flush_tag), counted modulo the tag space
	function automatic logic tag_is_older(tag_t t, flush_t f);
		tag_t age;
		tag_t span;
		age  = t - f.front_tag;
		span = f.flush_tag - f.front_tag;
		return age < span;
	endfunction

	// resolve a busy operand against this cycle's cdb and wakeup words
	function automatic src_t wake_src(src_t s, result_t cdb, result_t wk);
		src_t w;
		w = s;
		if (s.busy && cdb.valid && cdb.tag == s.op.rob.tag) begin
			w.busy     = 1'b0;
			w.op.value = cdb.value;
		end else if (s.busy && wk.valid && wk.tag == s.op.rob.tag) begin
			w.busy     = 1'b0;
			w.op.value = wk.value;
		end
		return w;
	endfunction

endpackage

// ==== reservation_station.sv ====
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reservation_station #(
	parameter int depth = `RS_DEPTH
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     issue_valid [2],
	input  ooo_types_pkg::rs_entry_t new_entry [2],
	input  ooo_types_pkg::result_t   cdb,
	input  ooo_types_pkg::result_t   rob_wakeup,
	input  ooo_types_pkg::flush_t    flush,
	input  logic                     alu_ready,
	input  logic                     cmp_ready,
	output logic                     issue_ready,
	output ooo_types_pkg::dispatch_t alu_disp,
	output ooo_types_pkg::dispatch_t cmp_disp
);
	import ooo_types_pkg::*;

	localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	rs_entry_t        ent [depth];
	logic [idx_w-1:0] free_idx [2];
	logic [cnt_w-1:0] free_cnt;
	logic [idx_w-1:0] alu_idx;
	logic [idx_w-1:0] cmp_idx;
	logic             alu_found;
	logic             cmp_found;
	logic             alu_take;
	logic             cmp_take;

	function automatic dispatch_t to_disp(rs_entry_t e, logic v, logic [2:0] op);
		dispatch_t d;
		d.valid = v;
		d.tag   = e.tag;
		d.op    = op;
		d.a     = e.src1.op.value;
		d.b     = e.src2.op.value;
		return d;
	endfunction

	// scan downward so the lowest index wins
	always_comb begin
		free_cnt    = '0;
		free_idx[0] = '0;
		free_idx[1] = '0;
		alu_found   = 1'b0;
		cmp_found   = 1'b0;
		alu_idx     = '0;
		cmp_idx     = '0;
		for (int i = depth - 1; i >= 0; i--) begin
			if (!ent[i].valid) begin
				free_cnt    = free_cnt + 1'b1;
				free_idx[1] = free_idx[0];
				free_idx[0] = idx_w'(i);
			end else if (!ent[i].src1.busy && !ent[i].src2.busy) begin
				if (ent[i].unit_cmp) begin
					cmp_found = 1'b1;
					cmp_idx   = idx_w'(i);
				end else begin
					alu_found = 1'b1;
					alu_idx   = idx_w'(i);
				end
			end
		end
	end

	// two free entries keep both slots safe in the same cycle
	assign issue_ready = free_cnt >= 2;

	assign alu_disp = to_disp(ent[alu_idx], alu_found, ent[alu_idx].alu_op);
	assign cmp_disp = to_disp(ent[cmp_idx], cmp_found, ent[cmp_idx].cmp_op);
	assign alu_take = alu_disp.valid && alu_ready;
	assign cmp_take = cmp_disp.valid && cmp_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < depth; i++) begin
				ent[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < depth; i++) begin
				ent[i].src1 <= wake_src(ent[i].src1, cdb, rob_wakeup);
				ent[i].src2 <= wake_src(ent[i].src2, cdb, rob_wakeup);
				if ((alu_take && alu_idx == idx_w'(i)) || (cmp_take && cmp_idx == idx_w'(i))) begin
					ent[i].valid <= 1'b0;
				end
				if (flush.valid && !tag_is_older(ent[i].tag, flush)) begin
					ent[i].valid <= 1'b0;
				end
			end
			// new entries are written over the wakeup update, the decoder
			// already bypassed this cycle's broadcasts
			if (!flush.valid && issue_ready) begin
				if (issue_valid[0]) begin
					ent[free_idx[0]] <= new_entry[0];
				end
				if (issue_valid[1]) begin
					ent[free_idx[1]] <= new_entry[1];
				end
			end
		end
	end

endmodule

// ==== rv32i_isa_pkg.sv ====
`include "ooo_consts.svh"

package rv32i_isa_pkg;

	// major opcodes handled by the integer cluster
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_t;

	typedef enum logic [2:0] {
		f3_add  = 3'b000,
		f3_sll  = 3'b001,
		f3_slt  = 3'b010,
		f3_sltu = 3'b011,
		f3_xor  = 3'b100,
		f3_sr   = 3'b101,
		f3_or   = 3'b110,
		f3_and  = 3'b111
	} arith_funct3_t;

	// sub and sra take the codes slt and sltu leave free in the alu,
	// so every other op maps straight from funct3
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sub = 3'b010,
		alu_sra = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_op_t;

	// same encoding as the branch funct3
	typedef enum logic [2:0] {
		cmp_beq  = 3'b000,
		cmp_bne  = 3'b001,
		cmp_blt  = 3'b100,
		cmp_bge  = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_op_t;

	typedef struct packed {
		logic [`XLEN_W-1:0] pc;
		opcode_t            opcode;
		logic [2:0]         funct3;
		logic [6:0]         funct7;
		logic [`XLEN_W-1:0] i_imm;
		logic [`XLEN_W-1:0] u_imm;
		logic [`XLEN_W-1:0] j_imm;
	} pci_t;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// reset held for 16 rising edges
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== tb_exec_cluster.sv ====
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_exec_cluster;
	import rv32i_isa_pkg::*;
	import ooo_types_pkg::*;

	logic        clk;
	logic        rst;
	logic        issue_valid [2];
	pci_t        issue_pci [2];
	src_t        issue_r1 [2];
	src_t        issue_r2 [2];
	tag_t        issue_tag [2];
	result_t     rob_wakeup;
	flush_t      flush;
	logic        issue_ready;
	result_t     cdb;
	logic [31:0] lfsr;
	logic        pending [16];
	logic        delivered [16];
	logic [31:0] exp_val [16];
	tag_t        next_tag;
	int          n_wrong;
	int          n_dup;
	int          n_unexp;
	int          n_missing;
	int          n_timeout;

	tb_clock_gen i_clk (.clk(clk), .rst(rst));

	exec_cluster i_dut (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_pci   (issue_pci),
		.issue_r1    (issue_r1),
		.issue_r2    (issue_r2),
		.issue_tag   (issue_tag),
		.rob_wakeup  (rob_wakeup),
		.flush       (flush),
		.issue_ready (issue_ready),
		.cdb         (cdb)
	);

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] get_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected architectural value from the rv32i rules
	function automatic logic [31:0] ref_value(pci_t p, logic [31:0] a, logic [31:0] b);
		logic [31:0] y;
		logic [31:0] bb;
		y  = '0;
		bb = (p.opcode == op_imm) ? p.i_imm : b;
		case (p.opcode)
			op_lui:   y = p.u_imm;
			op_auipc: y = p.pc + p.u_imm;
			op_jal:   y = p.pc + p.j_imm;
			op_jalr:  y = a + p.i_imm;
			op_br: begin
				case (p.funct3)
					3'd0: y = 32'(a == b);
					3'd1: y = 32'(a != b);
					3'd4: y = 32'($signed(a) < $signed(b));
					3'd5: y = 32'($signed(a) >= $signed(b));
					3'd6: y = 32'(a < b);
					3'd7: y = 32'(a >= b);
					default: y = '0;
				endcase
			end
			default: begin
				case (p.funct3)
					3'd0: y = (p.opcode == op_reg && p.funct7[5]) ? a - bb : a + bb;
					3'd1: y = a << bb[4:0];
					3'd2: y = 32'($signed(a) < $signed(bb));
					3'd3: y = 32'(a < bb);
					3'd4: y = a ^ bb;
					3'd5: y = p.funct7[5] ? $signed(a) >>> bb[4:0] : a >> bb[4:0];
					3'd6: y = a | bb;
					default: y = a & bb;
				endcase
			end
		endcase
		return y;
	endfunction

	function automatic src_t val_src(logic [31:0] v);
		src_t s;
		s.busy     = 1'b0;
		s.op.value = v;
		return s;
	endfunction

	function automatic src_t busy_src(tag_t t);
		src_t s;
		s.busy       = 1'b1;
		s.op.value   = '0;
		s.op.rob.tag = t;
		return s;
	endfunction

	function automatic pci_t reg_pci(logic [2:0] f3, logic [6:0] f7);
		pci_t p;
		p        = '0;
		p.opcode = op_reg;
		p.funct3 = f3;
		p.funct7 = f7;
		return p;
	endfunction

	task automatic rand_instr(output pci_t p);
		logic [31:0] r;
		logic [31:0] k;
		r       = get_bits(32);
		p.pc    = {r[31:2], 2'b00};
		r       = get_bits(32);
		p.u_imm = {r[31:12], 12'b0};
		p.j_imm = {{11{r[20]}}, r[20:1], 1'b0};
		r       = get_bits(12);
		p.i_imm = {{20{r[11]}}, r[11:0]};
		r        = get_bits(3);
		p.funct3 = r[2:0];
		r        = get_bits(1);
		p.funct7 = {1'b0, r[0], 5'b0};
		k        = get_bits(3);
		case (k[2:0])
			3'd0: p.opcode = op_lui;
			3'd1: p.opcode = op_auipc;
			3'd2: p.opcode = op_jal;
			3'd3: p.opcode = op_jalr;
			3'd4: p.opcode = op_br;
			3'd5: p.opcode = op_imm;
			default: p.opcode = op_reg;
		endcase
		// funct3 2 and 3 are not branches
		if (p.opcode == op_br && p.funct3[2:1] == 2'b01) begin
			p.funct3 = p.funct3 ^ 3'b100;
		end
		if (p.opcode == op_imm && p.funct3 == 3'd1) begin
			p.funct7 = '0;
		end
		if (p.opcode == op_imm && (p.funct3 == 3'd1 || p.funct3 == 3'd5)) begin
			p.i_imm = {20'b0, p.funct7, p.i_imm[4:0]};
		end
	endtask

	task automatic drive_slot(input int s, input pci_t p, input src_t r1, input src_t r2,
			input tag_t t, input logic [31:0] e, input logic scored);
		issue_valid[s] = 1'b1;
		issue_pci[s]   = p;
		issue_r1[s]    = r1;
		issue_r2[s]    = r2;
		issue_tag[s]   = t;
		pending[t]     = scored;
		delivered[t]   = 1'b0;
		exp_val[t]     = e;
	endtask

	// hold the driven slots until the edge that accepts them
	task automatic commit_issue();
		int t;
		t = 0;
		while (!issue_ready && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (t >= 200) begin
			n_timeout++;
			$display("timeout: issue_ready never rose at %0t", $time);
		end
		@(negedge clk);
		issue_valid[0] = 1'b0;
		issue_valid[1] = 1'b0;
	endtask

	task automatic wait_tag_free(input tag_t tg);
		int t;
		t = 0;
		while (pending[tg] && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (t >= 200) begin
			n_timeout++;
			$display("timeout: tag %0d never completed", tg);
		end
	endtask

	task automatic drain();
		int t;
		logic busy;
		t    = 0;
		busy = 1'b1;
		while (busy && t < 500) begin
			busy = 1'b0;
			for (int i = 0; i < 16; i++) begin
				busy = busy | pending[i];
			end
			if (busy) begin
				@(negedge clk);
				t++;
			end
		end
		if (busy) begin
			n_timeout++;
			$display("timeout: results still outstanding at %0t", $time);
		end
	endtask

	task automatic issue_random(input int pairs);
		pci_t        p;
		logic [31:0] a;
		logic [31:0] b;
		for (int n = 0; n < pairs; n++) begin
			wait_tag_free(next_tag);
			wait_tag_free(next_tag + 4'd1);
			for (int s = 0; s < 2; s++) begin
				rand_instr(p);
				a = get_bits(32);
				b = get_bits(32);
				drive_slot(s, p, val_src(a), val_src(b), next_tag, ref_value(p, a, b), 1'b1);
				next_tag = next_tag + 4'd1;
			end
			commit_issue();
		end
	endtask

	// pairs of subtractions blocked on tag 15 with tags counting up from base
	task automatic issue_blocked(input int pairs, input tag_t base, input logic [31:0] v);
		pci_t p;
		p = reg_pci(3'd0, 7'h20);
		for (int n = 0; n < pairs; n++) begin
			for (int s = 0; s < 2; s++) begin
				drive_slot(s, p, busy_src(4'd15), val_src(32'(n * 2 + s)),
					base + tag_t'(n * 2 + s), v - 32'(n * 2 + s), 1'b1);
			end
			commit_issue();
		end
	endtask

	task automatic wake(input tag_t t, input logic [31:0] v);
		rob_wakeup = '{valid: 1'b1, tag: t, value: v};
		@(negedge clk);
		rob_wakeup = '0;
	endtask

	always @(posedge clk) begin
		if (!rst && cdb.valid) begin
			if (pending[cdb.tag]) begin
				if (cdb.value !== exp_val[cdb.tag]) begin
					n_wrong++;
					$display("Error at %0t: tag %0d gave %h, expected %h", $time, cdb.tag,
						cdb.value, exp_val[cdb.tag]);
				end
				pending[cdb.tag]   = 1'b0;
				delivered[cdb.tag] = 1'b1;
			end else if (delivered[cdb.tag]) begin
				n_dup++;
				$display("Error at %0t: tag %0d broadcast twice", $time, cdb.tag);
			end else begin
				n_unexp++;
				$display("Error at %0t: unexpected tag %0d on cdb", $time, cdb.tag);
			end
		end
	end

	initial begin
		int t;
		pci_t p;
		lfsr       = 32'h23dd;
		next_tag   = '0;
		n_wrong    = 0;
		n_dup      = 0;
		n_unexp    = 0;
		n_missing  = 0;
		n_timeout  = 0;
		rob_wakeup = '0;
		flush      = '0;
		for (int s = 0; s < 2; s++) begin
			issue_valid[s] = 1'b0;
			issue_pci[s]   = '0;
			issue_r1[s]    = '0;
			issue_r2[s]    = '0;
			issue_tag[s]   = '0;
		end
		for (int i = 0; i < 16; i++) begin
			pending[i]   = 1'b0;
			delivered[i] = 1'b0;
			exp_val[i]   = '0;
		end
		t = 0;
		@(negedge clk);
		while (rst && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (rst) begin
			n_timeout++;
			$display("timeout: reset was never released");
		end
		if (!issue_ready || cdb.valid) begin
			n_wrong++;
			$display("Error at %0t: bad state after reset", $time);
		end

		// independent mix of every kind keeping both units busy
		issue_random(40);
		drain();

		// consumer issued with its producer still waiting
		p = reg_pci(3'd0, 7'h00);
		drive_slot(0, p, val_src(32'h1234), val_src(32'h0100), 4'd0, 32'h1334, 1'b1);
		drive_slot(1, reg_pci(3'd0, 7'h00), busy_src(4'd0), val_src(32'h5), 4'd1,
			32'h1339, 1'b1);
		commit_issue();
		drain();

		// consumer issued while its producer is on the cdb
		drive_slot(0, p, val_src(32'hf0f0), val_src(32'h0f0f), 4'd2, 32'hffff, 1'b1);
		commit_issue();
		t = 0;
		while (!(cdb.valid && cdb.tag == 4'd2) && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (t >= 50) begin
			n_timeout++;
			$display("timeout: producer tag 2 never reached the cdb");
		end
		drive_slot(0, reg_pci(3'd4, 7'h00), busy_src(4'd2), val_src(32'h00ff), 4'd3,
			32'hff00, 1'b1);
		commit_issue();

		// value only from the rob with slot 1 alone
		drive_slot(1, reg_pci(3'd0, 7'h20), busy_src(4'd14), val_src(32'd7), 4'd4,
			32'd93, 1'b1);
		commit_issue();
		repeat (3) @(negedge clk);
		wake(4'd14, 32'd100);
		drain();

		// fill the station behind tag 15 until one entry is left
		issue_blocked(3, 4'd0, 32'h8000);
		drive_slot(0, reg_pci(3'd0, 7'h20), busy_src(4'd15), val_src(32'd6), 4'd6,
			32'h7ffa, 1'b1);
		commit_issue();
		if (issue_ready) begin
			n_wrong++;
			$display("Error at %0t: issue_ready high with one entry free", $time);
		end
		drive_slot(0, p, val_src(32'd1), val_src(32'd1), 4'd8, 32'd2, 1'b0);
		drive_slot(1, p, val_src(32'd1), val_src(32'd1), 4'd9, 32'd2, 1'b0);
		repeat (4) @(negedge clk);
		issue_valid[0] = 1'b0;
		issue_valid[1] = 1'b0;
		wake(4'd15, 32'h8000);
		drain();

		// discard tags 3 to 5 and keep 0 to 2
		issue_blocked(3, 4'd0, 32'h4000);
		flush = '{valid: 1'b1, front_tag: 4'd0, flush_tag: 4'd3};
		for (int i = 3; i < 6; i++) begin
			pending[i] = 1'b0;
		end
		@(negedge clk);
		flush = '0;
		wake(4'd15, 32'h4000);
		drain();

		// compare wins the bus so the alu result is still held at the flush
		drive_slot(0, reg_pci(3'd2, 7'h00), val_src(32'd1), val_src(32'd2), 4'd6,
			32'd1, 1'b1);
		drive_slot(1, p, val_src(32'd3), val_src(32'd4), 4'd7, 32'd7, 1'b0);
		commit_issue();
		@(negedge clk);
		flush = '{valid: 1'b1, front_tag: 4'd6, flush_tag: 4'd7};
		@(negedge clk);
		flush = '0;
		drain();
		repeat (10) @(negedge clk);

		for (int i = 0; i < 16; i++) begin
			if (pending[i]) begin
				n_missing++;
				$display("tag %0d never appeared on the cdb", i);
			end
		end
		$display("wrong %0d, duplicate %0d, unexpected %0d, missing %0d, timeout %0d",
			n_wrong, n_dup, n_unexp, n_missing, n_timeout);
		if (n_wrong + n_dup + n_unexp + n_missing + n_timeout == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
